/* sim.f */
source/isa_pkg.sv
source/pipe_pkg.sv
source/regfile.sv
source/fetch_stage.sv
source/decode_stage.sv
source/exec_stage.sv
source/mem_stage.sv
source/mem_arbiter.sv
source/core_top.sv
test/core_assertions.sv
test/core_tb.sv

/* source/core_top.sv */
module core_top #(
  parameter isa_pkg::addr_t RESET_PC = '0
) (
  input  logic               clk,
  input  logic               rst_n,
  output pipe_pkg::mem_req_t mem_bus,
  input  isa_pkg::word_t     mem_rdata
);

  import pipe_pkg::*;

  logic     fs2ds_valid, ds_allowin, ds2es_valid, es_allowin, es2ms_valid, ms_allowin;
  fs2ds_t   fs2ds_bus;
  ds2es_t   ds2es_bus;
  es2ms_t   es2ms_bus;
  br_t      br;
  fwd_t     es_fwd, ms_fwd;
  wb_t      wb;
  mem_req_t ifetch_req, data_req;
  logic     ifetch_grant, data_grant;

  fetch_stage #(.RESET_PC(RESET_PC)) i_fetch_stage (
    .clk, .rst_n, .br, .ds_allowin, .fs2ds_valid, .fs2ds_bus,
    .ifetch_req, .ifetch_grant, .mem_rdata
  );

  decode_stage i_decode_stage (
    .clk, .rst_n, .fs2ds_valid, .fs2ds_bus, .ds_allowin, .es_allowin,
    .ds2es_valid, .ds2es_bus, .br, .es_fwd, .ms_fwd, .wb
  );

  exec_stage i_exec_stage (
    .clk, .rst_n, .ds2es_valid, .ds2es_bus, .es_allowin, .ms_allowin,
    .es2ms_valid, .es2ms_bus, .es_fwd
  );

  mem_stage i_mem_stage (
    .clk, .rst_n, .es2ms_valid, .es2ms_bus, .ms_allowin, .data_req,
    .data_grant, .mem_rdata, .ms_fwd, .wb
  );

  mem_arbiter i_mem_arbiter (
    .clk, .rst_n, .ifetch_req, .data_req, .ifetch_grant, .data_grant, .mem_bus
  );

endmodule

/* source/decode_stage.sv */
module decode_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             fs2ds_valid,
  input  pipe_pkg::fs2ds_t fs2ds_bus,
  output logic             ds_allowin,
  input  logic             es_allowin,
  output logic             ds2es_valid,
  output pipe_pkg::ds2es_t ds2es_bus,
  output pipe_pkg::br_t    br,
  input  pipe_pkg::fwd_t   es_fwd,
  input  pipe_pkg::fwd_t   ms_fwd,
  input  pipe_pkg::wb_t    wb
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic     ds_valid;
  addr_t    ds_pc;
  inst_t    ds_inst;
  reg_idx_t rj, rk, rd, raddr2;
  word_t    rdata1, rdata2, rj_val, rkd_val;
  word_t    imm, si12, off16, off26;
  logic     inst_reg_op, inst_addi, inst_ld, inst_st, inst_lu12i;
  logic     inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
  logic     use_rj, use_rkd, src2_is_imm, link, ready_go, take;
  alu_op_t  alu_op;

  // newest producer wins; r0 never forwards
  function automatic word_t fwd_pick(input reg_idx_t idx, input word_t rf_val);
    word_t val;
    val = rf_val;
    if (idx != '0) begin
      if (es_fwd.reg_we && es_fwd.dest == idx) val = es_fwd.value;
      else if (ms_fwd.reg_we && ms_fwd.dest == idx) val = ms_fwd.value;
      else if (wb.we && wb.addr == idx) val = wb.data;
    end
    return val;
  endfunction

  function automatic logic hazard(input reg_idx_t idx);
    return idx != '0 &&
           ((es_fwd.reg_we && es_fwd.pending && es_fwd.dest == idx) ||
            (ms_fwd.reg_we && ms_fwd.pending && ms_fwd.dest == idx));
  endfunction

  assign rd = ds_inst[4:0];
  assign rj = ds_inst[9:5];
  assign rk = ds_inst[14:10];

  assign inst_reg_op = ds_inst[31:15] inside {OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU,
                                              OP_NOR, OP_AND, OP_OR, OP_XOR};
  assign inst_addi  = ds_inst[31:22] == OP_ADDI_W;
  assign inst_ld    = ds_inst[31:22] == OP_LD_W;
  assign inst_st    = ds_inst[31:22] == OP_ST_W;
  assign inst_lu12i = ds_inst[31:25] == OP_LU12I_W;
  assign inst_jirl  = ds_inst[31:26] == OP_JIRL;
  assign inst_b     = ds_inst[31:26] == OP_B;
  assign inst_bl    = ds_inst[31:26] == OP_BL;
  assign inst_beq   = ds_inst[31:26] == OP_BEQ;
  assign inst_bne   = ds_inst[31:26] == OP_BNE;

  always_comb begin
    case (ds_inst[31:15])
      OP_SUB_W: alu_op = ALU_SUB;
      OP_SLT:   alu_op = ALU_SLT;
      OP_SLTU:  alu_op = ALU_SLTU;
      OP_AND:   alu_op = ALU_AND;
      OP_OR:    alu_op = ALU_OR;
      OP_XOR:   alu_op = ALU_XOR;
      OP_NOR:   alu_op = ALU_NOR;
      default:  alu_op = inst_lu12i ? ALU_LUI : ALU_ADD;
    endcase
  end

  // rd is the second source for stores and compares
  assign raddr2  = (inst_st || inst_beq || inst_bne) ? rd : rk;
  assign use_rj  = !(inst_b || inst_bl || inst_lu12i);
  assign use_rkd = inst_reg_op || inst_st || inst_beq || inst_bne;

  regfile i_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr1 (rj),
    .raddr2 (raddr2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wb     (wb)
  );

  assign rj_val  = fwd_pick(rj, rdata1);
  assign rkd_val = fwd_pick(raddr2, rdata2);

  assign si12  = {{20{ds_inst[21]}}, ds_inst[21:10]};
  assign off16 = {{14{ds_inst[25]}}, ds_inst[25:10], 2'b00};
  assign off26 = {{4{ds_inst[9]}}, ds_inst[9:0], ds_inst[25:10], 2'b00};

  assign link        = inst_bl || inst_jirl;
  assign src2_is_imm = inst_addi || inst_ld || inst_st || inst_lu12i || link;
  assign imm = link       ? 32'd4 :
               inst_lu12i ? {ds_inst[24:5], 12'b0} :
                            si12;

  assign ready_go = !((use_rj && hazard(rj)) || (use_rkd && hazard(raddr2)));

  assign ds_allowin  = !ds_valid || (ready_go && es_allowin);
  assign ds2es_valid = ds_valid && ready_go;

  assign take = (inst_beq && rj_val == rkd_val) || (inst_bne && rj_val != rkd_val) ||
                inst_b || inst_bl || inst_jirl;
  assign br.taken  = ds_valid && ready_go && es_allowin && take;
  assign br.target = inst_jirl ? rj_val + off16 :
                     ds_pc + ((inst_b || inst_bl) ? off26 : off16);

  assign ds2es_bus = '{pc: ds_pc, alu_op: alu_op,
                       src1: link ? ds_pc : rj_val,
                       src2: src2_is_imm ? imm : rkd_val,
                       st_data: rkd_val, is_load: inst_ld, is_store: inst_st,
                       reg_we: inst_reg_op || inst_addi || inst_ld || inst_lu12i || link,
                       dest: inst_bl ? reg_idx_t'(1) : rd};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ds_valid <= 1'b0;
    end else if (br.taken) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= fs2ds_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fs2ds_valid && ds_allowin) begin
      ds_pc   <= fs2ds_bus.pc;
      ds_inst <= fs2ds_bus.inst;
    end
  end

endmodule

/* source/exec_stage.sv */
module exec_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             ds2es_valid,
  input  pipe_pkg::ds2es_t ds2es_bus,
  output logic             es_allowin,
  input  logic             ms_allowin,
  output logic             es2ms_valid,
  output pipe_pkg::es2ms_t es2ms_bus,
  output pipe_pkg::fwd_t   es_fwd
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic   es_valid;
  ds2es_t es_bus;
  word_t  alu_res;

  assign es_allowin  = !es_valid || ms_allowin;
  assign es2ms_valid = es_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      es_valid <= 1'b0;
    end else if (es_allowin) begin
      es_valid <= ds2es_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ds2es_valid && es_allowin) begin
      es_bus <= ds2es_bus;
    end
  end

  always_comb begin
    case (es_bus.alu_op)
      ALU_SUB:  alu_res = es_bus.src1 - es_bus.src2;
      ALU_SLT:  alu_res = {31'b0, $signed(es_bus.src1) < $signed(es_bus.src2)};
      ALU_SLTU: alu_res = {31'b0, es_bus.src1 < es_bus.src2};
      ALU_AND:  alu_res = es_bus.src1 & es_bus.src2;
      ALU_OR:   alu_res = es_bus.src1 | es_bus.src2;
      ALU_XOR:  alu_res = es_bus.src1 ^ es_bus.src2;
      ALU_NOR:  alu_res = ~(es_bus.src1 | es_bus.src2);
      ALU_LUI:  alu_res = es_bus.src2;
      default:  alu_res = es_bus.src1 + es_bus.src2;
    endcase
  end

  assign es2ms_bus = '{pc: es_bus.pc, result: alu_res, st_data: es_bus.st_data,
                       is_load: es_bus.is_load, is_store: es_bus.is_store,
                       reg_we: es_bus.reg_we, dest: es_bus.dest};

  // a load here has only its address
  assign es_fwd = '{reg_we: es_valid && es_bus.reg_we, is_load: es_bus.is_load,
                    pending: es_bus.is_load, dest: es_bus.dest, value: alu_res};

endmodule

/* source/fetch_stage.sv */
module fetch_stage #(
  parameter isa_pkg::addr_t RESET_PC = '0
) (
  input  logic               clk,
  input  logic               rst_n,
  input  pipe_pkg::br_t      br,
  input  logic               ds_allowin,
  output logic               fs2ds_valid,
  output pipe_pkg::fs2ds_t   fs2ds_bus,
  output pipe_pkg::mem_req_t ifetch_req,
  input  logic               ifetch_grant,
  input  isa_pkg::word_t     mem_rdata
);

  import isa_pkg::*;
  import pipe_pkg::*;

  addr_t  pc;
  logic   started;
  logic   inflight;
  logic   discard;
  addr_t  inflight_pc;
  logic   hold_valid;
  fs2ds_t hold_bus;
  logic   live;

  // returning word, unless a branch killed it
  assign live = inflight && !discard;

  assign fs2ds_valid = hold_valid || live;
  assign fs2ds_bus   = hold_valid ? hold_bus : '{pc: inflight_pc, inst: mem_rdata};

  // request only if the output slot is free next cycle
  assign ifetch_req = '{req: started && (!fs2ds_valid || ds_allowin),
                        we: 1'b0, addr: pc, wdata: '0};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc         <= RESET_PC;
      started    <= 1'b0;
      inflight   <= 1'b0;
      discard    <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      started  <= 1'b1;
      inflight <= ifetch_grant;
      discard  <= br.taken;
      if (br.taken) begin
        pc <= br.target;
      end else if (ifetch_grant) begin
        pc <= pc + 32'd4;
      end
      if (br.taken) begin
        hold_valid <= 1'b0;
      end else if (live && !ds_allowin) begin
        hold_valid <= 1'b1;
      end else if (ds_allowin) begin
        hold_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ifetch_grant) begin
      inflight_pc <= pc;
    end
    if (live && !ds_allowin) begin
      hold_bus <= fs2ds_bus;
    end
  end

endmodule

/* source/isa_pkg.sv */
package isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // lui passes src2 straight through
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_LUI
  } alu_op_t;

  // 3R forms, compared against inst[31:15]
  localparam logic [16:0] OP_ADD_W = 17'h00020;
  localparam logic [16:0] OP_SUB_W = 17'h00022;
  localparam logic [16:0] OP_SLT   = 17'h00024;
  localparam logic [16:0] OP_SLTU  = 17'h00025;
  localparam logic [16:0] OP_NOR   = 17'h00028;
  localparam logic [16:0] OP_AND   = 17'h00029;
  localparam logic [16:0] OP_OR    = 17'h0002a;
  localparam logic [16:0] OP_XOR   = 17'h0002b;

  // 2RI12 forms, inst[31:22]
  localparam logic [9:0] OP_ADDI_W = 10'h00a;
  localparam logic [9:0] OP_LD_W   = 10'h0a2;
  localparam logic [9:0] OP_ST_W   = 10'h0a6;

  // 1RI20, inst[31:25]
  localparam logic [6:0] OP_LU12I_W = 7'h0a;

  // branches, inst[31:26]
  localparam logic [5:0] OP_JIRL = 6'h13;
  localparam logic [5:0] OP_B    = 6'h14;
  localparam logic [5:0] OP_BL   = 6'h15;
  localparam logic [5:0] OP_BEQ  = 6'h16;
  localparam logic [5:0] OP_BNE  = 6'h17;

endpackage

/* source/mem_arbiter.sv */
module mem_arbiter (
  input  logic               clk,
  input  logic               rst_n,
  input  pipe_pkg::mem_req_t ifetch_req,
  input  pipe_pkg::mem_req_t data_req,
  output logic               ifetch_grant,
  output logic               data_grant,
  output pipe_pkg::mem_req_t mem_bus
);

  import pipe_pkg::*;

  mem_req_t last_q;

  // data side always wins
  assign data_grant   = data_req.req;
  assign ifetch_grant = ifetch_req.req && !data_req.req;

  // idle bus keeps the last address and data to save toggles
  always_comb begin
    if (data_req.req) begin
      mem_bus = data_req;
    end else if (ifetch_req.req) begin
      mem_bus = ifetch_req;
    end else begin
      mem_bus = '{req: 1'b0, we: 1'b0, addr: last_q.addr, wdata: last_q.wdata};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_q <= '0;
    end else if (mem_bus.req) begin
      last_q <= mem_bus;
    end
  end

endmodule

/* source/mem_stage.sv */
module mem_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               es2ms_valid,
  input  pipe_pkg::es2ms_t   es2ms_bus,
  output logic               ms_allowin,
  output pipe_pkg::mem_req_t data_req,
  input  logic               data_grant,
  input  isa_pkg::word_t     mem_rdata,
  output pipe_pkg::fwd_t     ms_fwd,
  output pipe_pkg::wb_t      wb
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic   ms_valid;
  es2ms_t ms_bus;
  logic   ld_issued;
  logic   ready_go;
  word_t  final_res;

  // load read goes out once, data follows a cycle later
  assign data_req = '{req: ms_valid && (ms_bus.is_store || (ms_bus.is_load && !ld_issued)),
                      we: ms_bus.is_store, addr: ms_bus.result, wdata: ms_bus.st_data};

  assign ready_go = ms_bus.is_store ? data_grant :
                    ms_bus.is_load  ? ld_issued  :
                                      1'b1;

  assign ms_allowin = !ms_valid || ready_go;
  assign final_res  = ms_bus.is_load ? mem_rdata : ms_bus.result;

  assign wb = '{we: ms_valid && ready_go && ms_bus.reg_we, addr: ms_bus.dest,
                data: final_res};

  assign ms_fwd = '{reg_we: ms_valid && ms_bus.reg_we, is_load: ms_bus.is_load,
                    pending: ms_bus.is_load && !ld_issued, dest: ms_bus.dest,
                    value: final_res};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ms_valid  <= 1'b0;
      ld_issued <= 1'b0;
    end else begin
      if (ms_allowin) begin
        ms_valid <= es2ms_valid;
      end
      if (ms_valid && ready_go) begin
        ld_issued <= 1'b0;
      end else if (data_grant && ms_bus.is_load) begin
        ld_issued <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (es2ms_valid && ms_allowin) begin
      ms_bus <= es2ms_bus;
    end
  end

endmodule

/* source/pipe_pkg.sv */
package pipe_pkg;

  import isa_pkg::*;

  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fs2ds_t;

  typedef struct packed {
    addr_t    pc;
    alu_op_t  alu_op;
    word_t    src1;
    word_t    src2;
    word_t    st_data;
    logic     is_load;
    logic     is_store;
    logic     reg_we;
    reg_idx_t dest;
  } ds2es_t;

  typedef struct packed {
    addr_t    pc;
    word_t    result;
    word_t    st_data;
    logic     is_load;
    logic     is_store;
    logic     reg_we;
    reg_idx_t dest;
  } es2ms_t;

  typedef struct packed {
    logic  taken;
    addr_t target;
  } br_t;

  typedef struct packed {
    logic     we;
    reg_idx_t addr;
    word_t    data;
  } wb_t;

  // pending: value not produced yet
  typedef struct packed {
    logic     reg_we;
    logic     is_load;
    logic     pending;
    reg_idx_t dest;
    word_t    value;
  } fwd_t;

  // read data comes back on the cycle after the grant
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

endpackage

/* source/regfile.sv */
module regfile (
  input  logic               clk,
  input  logic               rst_n,
  input  isa_pkg::reg_idx_t  raddr1,
  input  isa_pkg::reg_idx_t  raddr2,
  output isa_pkg::word_t     rdata1,
  output isa_pkg::word_t     rdata2,
  input  pipe_pkg::wb_t      wb
);

  import isa_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we && wb.addr != '0) begin
      regs[wb.addr] <= wb.data;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* test/core_assertions.sv */
module core_assertions (
  input logic               clk,
  input logic               rst_n,
  input pipe_pkg::mem_req_t mem_bus,
  input logic               ifetch_grant,
  input logic               data_grant,
  input pipe_pkg::br_t      br,
  input logic               ds2es_valid
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  no_req_in_reset: assert property (@(posedge clk) !rst_n |-> !mem_bus.req)
    else begin
      fail_count++;
      $error("memory request while in reset");
    end

  word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
                                 mem_bus.req |-> mem_bus.addr[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("unaligned address %h on memory bus", mem_bus.addr);
    end

  // arbiter hands the port to one side only
  one_grant: assert property (@(posedge clk) disable iff (!rst_n)
                              !(ifetch_grant && data_grant))
    else begin
      fail_count++;
      $error("fetch and data granted together");
    end

  // taken branch comes from a valid decode slot, which is flushed right after
  branch_from_valid: assert property (@(posedge clk) disable iff (!rst_n)
                                      br.taken |-> ds2es_valid ##1 !ds2es_valid)
    else begin
      fail_count++;
      $error("branch taken without a valid decode instruction or without a flush");
    end

endmodule

/* test/core_tb.sv */
module core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import isa_pkg::*;
  import pipe_pkg::*;

  typedef enum logic [3:0] {
    K_ADD, K_SUB, K_SLT, K_SLTU, K_AND, K_OR, K_XOR, K_NOR,
    K_CHAIN, K_LOADUSE, K_BEQ, K_BNE, K_B, K_BL, K_JIRL
  } op_kind_t;

  typedef struct packed {
    op_kind_t kind;
    word_t    a;
    word_t    b;
  } case_row_t;

  localparam addr_t       PROG_BASE     = 32'h0000_0100;
  localparam addr_t       RESULT_ADDR   = 32'h0000_07f0;
  localparam addr_t       SCRATCH_ADDR  = 32'h0000_07e0;
  localparam logic [31:0] LFSR_SEED     = 32'h612541e9;
  localparam logic [31:0] LFSR_TAPS     = 32'h80200003;
  localparam int          STORE_TIMEOUT = 300;
  localparam int          NUM_CASES     = 21;

  // zero operands get LFSR values
  case_row_t case_table [NUM_CASES] = '{
    '{K_ADD, 32'h7fff_ffff, 32'h0000_0001}, '{K_ADD, 32'h0, 32'h0},
    '{K_SUB, 32'h0000_0005, 32'h0000_0007}, '{K_SUB, 32'h0, 32'h0},
    '{K_SLT, 32'hffff_fff0, 32'h0000_0003}, '{K_SLT, 32'h0000_0003, 32'hffff_fff0},
    '{K_SLTU, 32'hffff_fff0, 32'h0000_0003}, '{K_SLTU, 32'h0, 32'h0},
    '{K_AND, 32'h0, 32'h0}, '{K_OR, 32'h0, 32'h0},
    '{K_XOR, 32'h0, 32'h0}, '{K_NOR, 32'h0, 32'h0},
    '{K_CHAIN, 32'h1234_5fff, 32'h0000_0800}, '{K_LOADUSE, 32'h0, 32'h0},
    '{K_BEQ, 32'h1357_9bdf, 32'h1357_9bdf}, '{K_BEQ, 32'h1357_9bdf, 32'h1357_9bde},
    '{K_BNE, 32'h1357_9bdf, 32'h1357_9bdf}, '{K_BNE, 32'h1357_9bdf, 32'h1357_9bde},
    '{K_B, 32'h0, 32'h0}, '{K_BL, 32'h0, 32'h0}, '{K_JIRL, 32'h0, 32'h0}
  };

  // clock starts high so the first edge falls
  logic       clk = 1'b1;
  logic       rst_n = 1'b1;
  word_t      mem_rdata = '0;
  mem_req_t   mem_bus;
  word_t      mem [1024];
  word_t      image [1024];
  logic [9:0] rd_idx = '0;
  inst_t      prog [$];
  logic [31:0] lfsr_state = LFSR_SEED;

  always #10 clk = ~clk;

  core_top #(.RESET_PC(PROG_BASE)) i_core_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_bus   (mem_bus),
    .mem_rdata (mem_rdata)
  );

  bind core_top core_assertions i_core_assertions (
    .clk(clk), .rst_n(rst_n), .mem_bus(mem_bus), .ifetch_grant(ifetch_grant),
    .data_grant(data_grant), .br(br), .ds2es_valid(ds2es_valid)
  );

  // image reloads while in reset, read data follows on the next falling edge
  always @(posedge clk) begin
    if (!rst_n) begin
      mem <= image;
    end else if (mem_bus.req && mem_bus.we) begin
      mem[mem_bus.addr[11:2]] <= mem_bus.wdata;
    end else if (mem_bus.req) begin
      rd_idx <= mem_bus.addr[11:2];
    end
  end

  always @(negedge clk) begin
    mem_rdata <= mem[rd_idx];
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic draw_word(output word_t w);
    w = '0;
    for (int k = 0; k < 32; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
  endtask

  function automatic inst_t r3_word(input logic [16:0] op, input reg_idx_t rd,
                                    input reg_idx_t rj, input reg_idx_t rk);
    return {op, rk, rj, rd};
  endfunction

  function automatic inst_t ri12_word(input logic [9:0] op, input reg_idx_t rd,
                                      input reg_idx_t rj, input logic [11:0] imm);
    return {op, imm, rj, rd};
  endfunction

  function automatic inst_t br16_word(input logic [5:0] op, input reg_idx_t rj,
                                      input reg_idx_t rd, input logic [15:0] words);
    return {op, words, rj, rd};
  endfunction

  // offs[15:0] sits above offs[25:16]
  function automatic inst_t br26_word(input logic [5:0] op, input logic [25:0] words);
    return {op, words[15:0], words[25:16]};
  endfunction

  function automatic logic [16:0] reg_opcode(input op_kind_t kind);
    case (kind)
      K_SUB:   return OP_SUB_W;
      K_SLT:   return OP_SLT;
      K_SLTU:  return OP_SLTU;
      K_AND:   return OP_AND;
      K_OR:    return OP_OR;
      K_XOR:   return OP_XOR;
      K_NOR:   return OP_NOR;
      default: return OP_ADD_W;
    endcase
  endfunction

  // addi sign-extends, so round the upper part
  task automatic load_const(input reg_idx_t rd, input word_t val);
    word_t hi;
    hi = val + 32'h800;
    prog.push_back({OP_LU12I_W, hi[31:12], rd});
    prog.push_back(ri12_word(OP_ADDI_W, rd, rd, val[11:0]));
  endtask

  task automatic store_reg(input reg_idx_t rs);
    prog.push_back(ri12_word(OP_ST_W, rs, 5'd0, RESULT_ADDR[11:0]));
  endtask

  task automatic put_marker(input logic [11:0] marker);
    prog.push_back(ri12_word(OP_ADDI_W, 5'd6, 5'd0, marker));
    store_reg(5'd6);
  endtask

  task automatic build_program(input op_kind_t kind, input word_t a, input word_t b,
                               output addr_t bl_pc);
    int land;
    prog.delete();
    bl_pc = '0;
    load_const(5'd4, a);
    load_const(5'd5, b);
    case (kind)
      K_CHAIN: begin
        prog.push_back(r3_word(OP_ADD_W, 5'd6, 5'd4, 5'd5));
        prog.push_back(r3_word(OP_ADD_W, 5'd7, 5'd6, 5'd5));
        prog.push_back(r3_word(OP_ADD_W, 5'd8, 5'd7, 5'd6));
        prog.push_back(r3_word(OP_ADD_W, 5'd9, 5'd8, 5'd4));
        store_reg(5'd9);
      end
      K_LOADUSE: begin
        prog.push_back(ri12_word(OP_ST_W, 5'd4, 5'd0, SCRATCH_ADDR[11:0]));
        prog.push_back(ri12_word(OP_LD_W, 5'd6, 5'd0, SCRATCH_ADDR[11:0]));
        prog.push_back(r3_word(OP_ADD_W, 5'd7, 5'd6, 5'd5));
        store_reg(5'd7);
      end
      K_BEQ, K_BNE: begin
        prog.push_back(br16_word(kind == K_BEQ ? OP_BEQ : OP_BNE, 5'd4, 5'd5, 16'd4));
        put_marker(12'd2);
        prog.push_back(br26_word(OP_B, 26'd0));
        put_marker(12'd1);
      end
      K_B: begin
        prog.push_back(br26_word(OP_B, 26'd3));
        put_marker(12'd2);
        put_marker(12'd1);
      end
      K_BL: begin
        bl_pc = PROG_BASE + addr_t'(4 * prog.size());
        prog.push_back(br26_word(OP_BL, 26'd3));
        put_marker(12'd2);
        store_reg(5'd1);
      end
      K_JIRL: begin
        // jirl lands past the wrong marker
        land = prog.size() + 5;
        load_const(5'd7, PROG_BASE + word_t'(4 * land));
        prog.push_back(br16_word(OP_JIRL, 5'd7, 5'd0, 16'd0));
        put_marker(12'd2);
        put_marker(12'd1);
      end
      default: begin
        prog.push_back(r3_word(reg_opcode(kind), 5'd6, 5'd4, 5'd5));
        store_reg(5'd6);
      end
    endcase
    // spin here
    prog.push_back(br26_word(OP_B, 26'd0));
  endtask

  function automatic word_t expected_store(input op_kind_t kind, input word_t a,
                                           input word_t b, input addr_t bl_pc);
    case (kind)
      K_ADD:     return a + b;
      K_SUB:     return a - b;
      K_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      K_SLTU:    return (a < b) ? 32'd1 : 32'd0;
      K_AND:     return a & b;
      K_OR:      return a | b;
      K_XOR:     return a ^ b;
      K_NOR:     return ~(a | b);
      K_CHAIN:   return (a + b) * 32'd3;
      K_LOADUSE: return a + b;
      K_BEQ:     return (a == b) ? 32'd1 : 32'd2;
      K_BNE:     return (a != b) ? 32'd1 : 32'd2;
      K_BL:      return bl_pc + 32'd4;
      default:   return 32'd1;
    endcase
  endfunction

  task automatic reset_core();
    addr_t addr;
    @(negedge clk);
    rst_n = 1'b0;
    for (int k = 0; k < 1024; k++) begin
      addr = addr_t'(k) << 2;
      image[k] = ~addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;
    end
    foreach (prog[k]) begin
      image[int'(PROG_BASE[11:2]) + k] = prog[k];
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // scratch stores of the load-use program are skipped
  task automatic wait_result_store(input int row_idx, output mem_req_t seen);
    int   cycles;
    logic found;
    cycles = 0;
    found = 1'b0;
    seen = '0;
    while (!found && cycles < STORE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (mem_bus.req && mem_bus.we && mem_bus.addr != SCRATCH_ADDR) begin
        found = 1'b1;
        seen = mem_bus;
      end
    end
    if (!found) begin
      $display("timeout: case %0d made no store within %0d cycles", row_idx, STORE_TIMEOUT);
      $display("TEST RESULT: FAIL");
      $fatal(1, "no result store");
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: store address %h, expected %h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_data(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: store data %h, expected %h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "data mismatch");
    end
  endtask

  initial begin
    case_row_t row;
    word_t     a;
    word_t     b;
    addr_t     bl_pc;
    mem_req_t  seen;
    string     label;
    for (int i = 0; i < NUM_CASES; i++) begin
      row = case_table[i];
      a = row.a;
      b = row.b;
      if (a == '0) draw_word(a);
      if (b == '0) draw_word(b);
      build_program(row.kind, a, b, bl_pc);
      reset_core();
      wait_result_store(i, seen);
      label = $sformatf("case %0d (%s)", i, row.kind.name());
      check_addr(seen.addr, RESULT_ADDR, label);
      check_data(seen.wdata, expected_store(row.kind, a, b, bl_pc), label);
    end
    if (i_core_top.i_core_assertions.fail_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "%0d assertion failures", i_core_top.i_core_assertions.fail_count);
    end
  end

endmodule
